// File: Makefile
# Verilator build and run of the cosine similarity testbench
TOP   := cosine_tb
FLIST := cosine_similarity.f
SRCS  := $(shell cat $(FLIST))

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST) $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f $(FLIST) --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/cosine_tb.sv
// Testbench for the cosine similarity engine that runs as top module over the project file list
`timescale 1ns/100ps

module cosine_tb;

  import cosine_fmt_pkg::*;

  localparam int DATA_W    = DATA_W_DEF;
  localparam int LEN_W     = LEN_W_DEF;
  localparam int FRAC_BITS = FRAC_BITS_DEF;
  localparam int RES_W     = res_width(FRAC_BITS);

  // 149 elements at about 4 cycles, 12 rows at about 30 cycles, then a wide margin
  localparam int unsigned TIMEOUT_CYCLES = 4000;

  logic CLK;
  logic RST;
  logic start;
  logic [LEN_W-1:0] rows;
  logic [LEN_W-1:0] length;
  logic done;
  logic elem_req;
  logic signed [DATA_W-1:0] elem_a;
  logic signed [DATA_W-1:0] elem_b;
  logic elem_ack;
  logic res_req;
  logic signed [RES_W-1:0] res_value;
  logic res_zero;
  logic res_ack;

  // Stimulus of the current job in row order
  logic signed [DATA_W-1:0] stim_a[$];
  logic signed [DATA_W-1:0] stim_b[$];

  // Expected results in row order
  logic signed [RES_W-1:0] exp_val_q[$];
  logic exp_zero_q[$];

  // Expected value of the result being acknowledged
  logic signed [RES_W-1:0] exp_value;
  logic exp_zero;

  logic started;
  int job_rows;
  int res_count;
  int done_count;
  integer seed;
  int unsigned cycle_count = 0;

  cosine_similarity_top #(
    .DATA_W(DATA_W), .LEN_W(LEN_W), .FRAC_BITS(FRAC_BITS)
  ) u_dut (
    .CLK(CLK), .RST(RST),
    .start(start), .rows(rows), .length(length), .done(done),
    .elem_req(elem_req), .elem_a(elem_a), .elem_b(elem_b), .elem_ack(elem_ack),
    .res_req(res_req), .res_value(res_value), .res_zero(res_zero), .res_ack(res_ack)
  );

  ////////////////////////////////////////
  // Clock, cycle count, timeout
  ////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  always @(posedge CLK) begin
    if (done) begin
      done_count <= done_count + 1;
    end
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_on_error();
  end

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////

  task automatic push_pair(input int a, input int b);
    stim_a.push_back(DATA_W'(a));
    stim_b.push_back(DATA_W'(b));
  endtask

  task automatic fill_random(input int count);
    int k;
    for (k = 0; k < count; k++) begin
      push_pair($random(seed), $random(seed));
    end
  endtask

  // sign(dot) * dot^2 * 2^FRAC_BITS / (|a|^2 * |b|^2) truncated toward zero
  task automatic model_row(input int base, input int len);
    longint dot;
    longint na;
    longint nb;
    longint num;
    longint quo;
    int i;
    dot = 0;
    na  = 0;
    nb  = 0;
    for (i = 0; i < len; i++) begin
      dot += longint'(stim_a[base+i]) * longint'(stim_b[base+i]);
      na  += longint'(stim_a[base+i]) * longint'(stim_a[base+i]);
      nb  += longint'(stim_b[base+i]) * longint'(stim_b[base+i]);
    end
    if (na == 0 || nb == 0) begin
      exp_val_q.push_back('0);
      exp_zero_q.push_back(1'b1);
    end else begin
      num = (dot < 0) ? -dot : dot;
      quo = (num * num * (longint'(1) << FRAC_BITS)) / (na * nb);
      if (dot < 0) begin
        quo = -quo;
      end
      exp_val_q.push_back(RES_W'(quo));
      exp_zero_q.push_back(1'b0);
    end
  endtask

  ////////////////////////////////////////
  // Handshake drivers
  ////////////////////////////////////////

  // Four-phase source holding the data while elem_req is high
  task automatic send_elements(input int count);
    int k;
    for (k = 0; k < count; k++) begin
      elem_a   = stim_a[k];
      elem_b   = stim_b[k];
      elem_req = 1'b1;
      @(negedge CLK);
      while (!elem_ack) @(negedge CLK);
      elem_req = 1'b0;
      @(negedge CLK);
      while (elem_ack) @(negedge CLK);
    end
  endtask

  // Four-phase sink with a random answer delay
  task automatic take_results(input int count);
    int k;
    int delay;
    for (k = 0; k < count; k++) begin
      @(negedge CLK);
      while (!res_req) @(negedge CLK);
      delay = $unsigned($random(seed)) % 8;
      repeat (delay) @(negedge CLK);
      exp_value = exp_val_q.pop_front();
      exp_zero  = exp_zero_q.pop_front();
      res_ack = 1'b1;
      @(negedge CLK);
      while (res_req) @(negedge CLK);
      res_ack   = 1'b0;
      res_count = res_count + 1;
    end
  endtask

  // One job over the stimulus already queued followed by the done check
  task automatic run_job(input int n_rows, input int n_len);
    int r;
    int done_base;
    for (r = 0; r < n_rows; r++) begin
      model_row(r * n_len, n_len);
    end
    done_base = done_count;
    job_rows  = res_count + n_rows;
    rows      = LEN_W'(n_rows);
    length    = LEN_W'(n_len);
    start     = 1'b1;
    started   = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    fork
      send_elements(n_rows * n_len);
      take_results(n_rows);
    join
    while (done_count == done_base) @(negedge CLK);
    repeat (3) @(negedge CLK);
    assert (done_count - done_base == 1) else begin
      $display("[FAIL] %0t: done pulsed %0d times in one job", $time, done_count - done_base);
      stop_on_error();
    end
    stim_a.delete();
    stim_b.delete();
  endtask

  ////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////

  // Quiet outputs before the first job
  a_idle_quiet : assert property (@(posedge CLK) disable iff (RST)
    !started |-> (!elem_ack && !res_req && !done)) else begin
    $display("[FAIL] %0t: output active before start", $time);
    stop_on_error();
  end

  a_ack_needs_req : assert property (@(posedge CLK) disable iff (RST)
    (!elem_req && !elem_ack) |=> !elem_ack) else begin
    $display("[FAIL] %0t: elem_ack rose with elem_req low", $time);
    stop_on_error();
  end

  // Next row stalls while a result is pending
  a_no_ack_while_result : assert property (@(posedge CLK) disable iff (RST)
    !(elem_ack && res_req)) else begin
    $display("[FAIL] %0t: elem_ack high while res_req pending", $time);
    stop_on_error();
  end

  // No result beyond the rows of the running job
  a_result_expected : assert property (@(posedge CLK) disable iff (RST)
    res_req |-> (res_count < job_rows)) else begin
    $display("The DUT offered more results than the job has rows");
    stop_on_error();
  end

  a_result_value : assert property (@(posedge CLK) disable iff (RST)
    (res_req && res_ack) |-> (res_value == exp_value && res_zero == exp_zero)) else begin
    $display("[FAIL] %0t: result %0d zero %0b, expected %0d zero %0b",
             $time, res_value, res_zero, exp_value, exp_zero);
    stop_on_error();
  end

  a_result_stable : assert property (@(posedge CLK) disable iff (RST)
    (res_req && !res_ack) |=> ($stable(res_value) && $stable(res_zero))) else begin
    $display("[FAIL] %0t: result changed while offered", $time);
    stop_on_error();
  end

  // done only after the last handshake and one cycle wide
  a_done_after_last : assert property (@(posedge CLK) disable iff (RST)
    done |-> (res_count == job_rows && !res_req && !res_ack)) else begin
    $display("[FAIL] %0t: done with %0d of %0d results", $time, res_count, job_rows);
    stop_on_error();
  end

  a_done_pulse : assert property (@(posedge CLK) disable iff (RST)
    done |=> !done) else begin
    $display("[FAIL] %0t: done longer than one cycle", $time);
    stop_on_error();
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int j;
    int len;
    seed      = 32'hb043_af10;
    RST       = 1'b1;
    start     = 1'b0;
    rows      = '0;
    length    = '0;
    elem_req  = 1'b0;
    elem_a    = '0;
    elem_b    = '0;
    res_ack   = 1'b0;
    exp_value = '0;
    exp_zero  = 1'b0;
    started   = 1'b0;
    job_rows  = 0;
    res_count = 0;
    done_count = 0;
    repeat (5) @(negedge CLK);
    RST = 1'b0;
    // Idle window for the quiet check
    repeat (4) @(negedge CLK);

    // Positive row of four
    push_pair(1, 4);
    push_pair(2, 3);
    push_pair(3, 2);
    push_pair(4, 1);
    run_job(1, 4);

    // Opposite signs, then a vector against itself
    push_pair(3, -4);
    push_pair(-5, 6);
    push_pair(7, -5);
    push_pair(10, -12);
    push_pair(-2, 3);
    push_pair(1, -1);
    push_pair(-128, -128);
    push_pair(127, 127);
    push_pair(50, 50);
    push_pair(-7, -7);
    push_pair(0, 0);
    push_pair(64, 64);
    run_job(2, 6);

    // Zero a vector
    for (j = 0; j < 5; j++) begin
      push_pair(0, $random(seed));
    end
    run_job(1, 5);

    // Eight random rows in two jobs
    for (j = 0; j < 2; j++) begin
      len = 1 + ($unsigned($random(seed)) % 16);
      fill_random(4 * len);
      run_job(4, len);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: common/cosine_ctrl_pkg.sv
// Control encodings of the similarity engine, imported by the sequencer and the combiner
package cosine_ctrl_pkg;

  // Row sequencer, one state per handshake phase
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_ROW_START,
    SEQ_ELEM_WAIT,
    SEQ_ELEM_RELEASE,
    SEQ_COMBINE_WAIT,
    SEQ_RESULT_HOLD,
    SEQ_RESULT_RELEASE
  } seq_state_t;

  // Combiner, square then iterate the divider
  typedef enum logic [1:0] {
    COMB_IDLE,
    COMB_SQUARE,
    COMB_DIVIDE,
    COMB_HOLD
  } comb_state_t;

  // Result status, zero norm forces a zero value
  typedef enum logic {
    RES_NORMAL    = 1'b0,
    RES_ZERO_NORM = 1'b1
  } res_status_t;

endpackage

// File: common/cosine_fmt_pkg.sv
// Number format defaults and width helpers, imported by every module of the similarity engine
package cosine_fmt_pkg;

  ////////////////////////////////////////
  // Format defaults
  ////////////////////////////////////////

  // Signed element width
  localparam int DATA_W_DEF = 8;

  // Row length and row count width
  localparam int LEN_W_DEF = 8;

  // Fraction bits of a similarity result
  localparam int FRAC_BITS_DEF = 12;

  ////////////////////////////////////////
  // Derived widths
  ////////////////////////////////////////

  // Full product plus growth for up to 2**len_w terms
  function automatic int acc_width(input int data_w, input int len_w);
    return 2 * data_w + len_w;
  endfunction

  // Sign, one integer bit, then the fraction
  function automatic int res_width(input int frac_bits);
    return frac_bits + 2;
  endfunction

endpackage

// File: common/element_if.sv
// Element bus from the row sequencer to both accumulators, one accepted pair per valid
`timescale 1ns/100ps

interface element_if #(
  parameter int DATA_W = 8
);

  // Row start, zeroes the sums
  logic clear;

  // One element pair accepted this cycle
  logic valid;

  // Element pair, stable while valid
  logic signed [DATA_W-1:0] a;
  logic signed [DATA_W-1:0] b;

  // Final pair of the row, qualified by valid
  logic last;

  // Sequencer side
  modport src (
    output clear,
    output valid,
    output a,
    output b,
    output last
  );

  // Accumulator side
  modport acc (
    input clear,
    input valid,
    input a,
    input b,
    input last
  );

endinterface

// File: cosine_similarity.f
common/cosine_fmt_pkg.sv
common/cosine_ctrl_pkg.sv
common/element_if.sv
hw/accum/dot_accumulator.sv
hw/accum/norm_accumulator.sv
hw/combine/cosine_combiner.sv
hw/cosine_row_sequencer.sv
hw/cosine_similarity_top.sv
bench/cosine_tb.sv

// File: hw/accum/dot_accumulator.sv
// Signed multiply-accumulate of a times b over one row, read by the combiner at row end
`timescale 1ns/100ps

module dot_accumulator #(
  parameter int DATA_W = cosine_fmt_pkg::DATA_W_DEF,
  parameter int LEN_W  = cosine_fmt_pkg::LEN_W_DEF
) (
  input  logic CLK,
  input  logic RST,

  // Accepted elements
  element_if.acc elem,

  // Row sum
  output logic signed [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] dot_sum,
  output logic sum_valid
);

  import cosine_fmt_pkg::*;

  localparam int ACC_W = acc_width(DATA_W, LEN_W);

  // Full signed product
  logic signed [2*DATA_W-1:0] prod;
  // Sign extended to the sum width
  logic signed [ACC_W-1:0] prod_ext;

  assign prod     = elem.a * elem.b;
  assign prod_ext = prod;

  ////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot_sum   <= '0;
      sum_valid <= 1'b0;
    end else if (elem.clear) begin
      dot_sum   <= '0;
      sum_valid <= 1'b0;
    end else if (elem.valid) begin
      dot_sum <= dot_sum + prod_ext;
      // Sum complete with the last pair, held until next clear
      if (elem.last) begin
        sum_valid <= 1'b1;
      end
    end
  end

  // Sequencer never accepts an element during row start
  a_no_valid_on_clear : assert property (
    @(posedge CLK) disable iff (RST) !(elem.valid && elem.clear)
  ) else $error("element accepted in the row start cycle");

endmodule

// File: hw/accum/norm_accumulator.sv
// Parallel sums of a squared and b squared over one row, the norm inputs of the combiner
`timescale 1ns/100ps

module norm_accumulator #(
  parameter int DATA_W = cosine_fmt_pkg::DATA_W_DEF,
  parameter int LEN_W  = cosine_fmt_pkg::LEN_W_DEF
) (
  input  logic CLK,
  input  logic RST,

  // Accepted elements
  element_if.acc elem,

  // Squared norms, never negative
  output logic [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] norm_a,
  output logic [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] norm_b,
  output logic sum_valid
);

  import cosine_fmt_pkg::*;

  localparam int ACC_W = acc_width(DATA_W, LEN_W);

  // Squares, MSB always clear
  logic signed [2*DATA_W-1:0] sq_a;
  logic signed [2*DATA_W-1:0] sq_b;
  logic [ACC_W-1:0] sq_a_ext;
  logic [ACC_W-1:0] sq_b_ext;

  assign sq_a     = elem.a * elem.a;
  assign sq_b     = elem.b * elem.b;
  assign sq_a_ext = ACC_W'($unsigned(sq_a));
  assign sq_b_ext = ACC_W'($unsigned(sq_b));

  ////////////////////////////////////////
  // Accumulate both norms
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      norm_a    <= '0;
      norm_b    <= '0;
      sum_valid <= 1'b0;
    end else if (elem.clear) begin
      norm_a    <= '0;
      norm_b    <= '0;
      sum_valid <= 1'b0;
    end else if (elem.valid) begin
      norm_a <= norm_a + sq_a_ext;
      norm_b <= norm_b + sq_b_ext;
      // Same row end as the dot sum
      if (elem.last) begin
        sum_valid <= 1'b1;
      end
    end
  end

  // No pair may follow the last one before the next row start
  a_no_elem_after_last : assert property (
    @(posedge CLK) disable iff (RST) sum_valid |-> !elem.valid
  ) else $error("element accepted after the end of the row");

endmodule

// File: hw/combine/cosine_combiner.sv
// Signed squared cosine of one row from the accumulator sums, via a restoring divider
`timescale 1ns/100ps

module cosine_combiner #(
  parameter int DATA_W    = cosine_fmt_pkg::DATA_W_DEF,
  parameter int LEN_W     = cosine_fmt_pkg::LEN_W_DEF,
  parameter int FRAC_BITS = cosine_fmt_pkg::FRAC_BITS_DEF
) (
  input  logic CLK,
  input  logic RST,

  // Row sums from the accumulators
  input  logic start_dot,
  input  logic start_norm,
  input  logic signed [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] dot_sum,
  input  logic [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] norm_a,
  input  logic [cosine_fmt_pkg::acc_width(DATA_W, LEN_W)-1:0] norm_b,

  // Result to the sequencer
  input  logic comb_take,
  output logic comb_done,
  output logic signed [cosine_fmt_pkg::res_width(FRAC_BITS)-1:0] comb_result,
  output logic comb_zero
);

  import cosine_fmt_pkg::*;
  import cosine_ctrl_pkg::*;

  localparam int ACC_W  = acc_width(DATA_W, LEN_W);
  localparam int RES_W  = res_width(FRAC_BITS);
  localparam int PROD_W = 2 * ACC_W;
  // Remainder stays below four times the divisor
  localparam int REM_W  = PROD_W + 2;
  // One quotient bit per step, weights 2 down to 2**-FRAC_BITS
  localparam int STEPS  = FRAC_BITS + 2;
  localparam int STEP_W = $clog2(STEPS);

  comb_state_t state_q;
  res_status_t status_q;
  logic both;
  logic both_q;
  logic start_job;
  logic stepping;
  logic last_step;
  logic [STEP_W-1:0] step_q;

  // Squaring
  logic [ACC_W-1:0] dot_mag;
  logic [PROD_W-1:0] dot_sq;
  logic [PROD_W-1:0] norm_prod;

  // Divider datapath
  logic [REM_W-1:0] rem_q;
  logic [REM_W-1:0] div2_q;
  logic [REM_W-1:0] rem_diff;
  logic [RES_W-1:0] quo_q;
  logic [RES_W-1:0] quo_next;
  logic quo_bit;
  logic neg_q;

  // Sums stay valid until next clear, so start on the rising edge only
  assign both      = start_dot && start_norm;
  assign start_job = (state_q == COMB_IDLE) && both && !both_q;
  assign stepping  = (state_q == COMB_SQUARE) || (state_q == COMB_DIVIDE);
  assign last_step = (state_q == COMB_DIVIDE) && (step_q == STEP_W'(STEPS - 1));

  // Magnitude, most negative value maps to itself as unsigned
  assign dot_mag   = dot_sum[ACC_W-1] ? $unsigned(-dot_sum) : $unsigned(dot_sum);
  assign dot_sq    = dot_mag * dot_mag;
  assign norm_prod = norm_a * norm_b;

  // Restoring step against a fixed 2*D, remainder doubles each step
  assign quo_bit   = (rem_q >= div2_q);
  assign rem_diff  = quo_bit ? (rem_q - div2_q) : rem_q;
  assign quo_next  = {quo_q[RES_W-2:0], quo_bit};

  assign comb_zero = (status_q == RES_ZERO_NORM);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= COMB_IDLE;
      both_q    <= 1'b0;
      step_q    <= '0;
      comb_done <= 1'b0;
    end else begin
      both_q <= both;
      case (state_q)
        COMB_IDLE: begin
          if (start_job) begin
            step_q  <= '0;
            state_q <= COMB_SQUARE;
          end
        end
        // Fresh squares, integer quotient bit
        COMB_SQUARE: begin
          step_q  <= step_q + 1'b1;
          state_q <= COMB_DIVIDE;
        end
        COMB_DIVIDE: begin
          if (last_step) begin
            comb_done <= 1'b1;
            state_q   <= COMB_HOLD;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        // Result held until the sequencer copies it
        COMB_HOLD: begin
          if (comb_take) begin
            comb_done <= 1'b0;
            state_q   <= COMB_IDLE;
          end
        end
        default: state_q <= COMB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_job) begin
      rem_q    <= REM_W'(dot_sq);
      div2_q   <= {1'b0, norm_prod, 1'b0};
      quo_q    <= '0;
      neg_q    <= dot_sum[ACC_W-1];
      status_q <= ((norm_a == '0) || (norm_b == '0)) ? RES_ZERO_NORM : RES_NORMAL;
    end else if (stepping) begin
      // Top bit is zero after the subtract
      rem_q <= {rem_diff[REM_W-2:0], 1'b0};
      quo_q <= quo_next;
    end
    // Sign last, magnitude truncated so the value rounds toward zero
    if (last_step) begin
      if (status_q == RES_ZERO_NORM) begin
        comb_result <= '0;
      end else if (neg_q) begin
        comb_result <= -$signed(quo_next);
      end else begin
        comb_result <= $signed(quo_next);
      end
    end
  end

  // Release only a result that is actually held
  a_take_while_done : assert property (
    @(posedge CLK) disable iff (RST) comb_take |-> comb_done
  ) else $error("comb_take without a held result");

endmodule

// File: hw/cosine_row_sequencer.sv
// Job sequencer, runs the element and result four-phase handshakes and counts rows and elements
`timescale 1ns/100ps

module cosine_row_sequencer #(
  parameter int DATA_W    = cosine_fmt_pkg::DATA_W_DEF,
  parameter int LEN_W     = cosine_fmt_pkg::LEN_W_DEF,
  parameter int FRAC_BITS = cosine_fmt_pkg::FRAC_BITS_DEF
) (
  input  logic CLK,
  input  logic RST,

  // Job control
  input  logic start,
  input  logic [LEN_W-1:0] rows,
  input  logic [LEN_W-1:0] length,
  output logic done,

  // Element handshake
  input  logic elem_req,
  input  logic signed [DATA_W-1:0] elem_a,
  input  logic signed [DATA_W-1:0] elem_b,
  output logic elem_ack,

  // Combiner
  input  logic comb_done,
  input  logic signed [cosine_fmt_pkg::res_width(FRAC_BITS)-1:0] comb_result,
  input  logic comb_zero,
  output logic comb_take,

  // Result handshake
  output logic res_req,
  output logic signed [cosine_fmt_pkg::res_width(FRAC_BITS)-1:0] res_value,
  output logic res_zero,
  input  logic res_ack,

  // Element bus to both accumulators
  element_if.src elem
);

  import cosine_ctrl_pkg::*;

  seq_state_t state_q;

  // Job geometry, latched at start
  logic [LEN_W-1:0] rows_q;
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] row_cnt;
  logic [LEN_W-1:0] elem_cnt;

  logic accept;
  logic row_end;
  logic job_end;
  logic take_result;

  assign accept      = (state_q == SEQ_ELEM_WAIT) && elem_req;
  assign take_result = (state_q == SEQ_COMBINE_WAIT) && comb_done;
  assign row_end     = (elem_cnt == len_q - 1'b1);
  assign job_end     = (row_cnt == rows_q - 1'b1);

  // One cycle pulse, state lasts exactly one cycle
  assign elem.clear = (state_q == SEQ_ROW_START);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= SEQ_IDLE;
      rows_q     <= '0;
      len_q      <= '0;
      row_cnt    <= '0;
      elem_cnt   <= '0;
      elem_ack   <= 1'b0;
      elem.valid <= 1'b0;
      res_req    <= 1'b0;
      comb_take  <= 1'b0;
      done       <= 1'b0;
    end else begin
      // Pulses
      elem.valid <= 1'b0;
      comb_take  <= 1'b0;
      done       <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (start) begin
            rows_q  <= rows;
            len_q   <= length;
            row_cnt <= '0;
            state_q <= SEQ_ROW_START;
          end
        end
        SEQ_ROW_START: begin
          elem_cnt <= '0;
          state_q  <= SEQ_ELEM_WAIT;
        end
        // Ack and valid on the same edge
        SEQ_ELEM_WAIT: begin
          if (elem_req) begin
            elem_ack   <= 1'b1;
            elem.valid <= 1'b1;
            state_q    <= SEQ_ELEM_RELEASE;
          end
        end
        SEQ_ELEM_RELEASE: begin
          if (!elem_req) begin
            elem_ack <= 1'b0;
            if (elem.last) begin
              state_q <= SEQ_COMBINE_WAIT;
            end else begin
              elem_cnt <= elem_cnt + 1'b1;
              state_q  <= SEQ_ELEM_WAIT;
            end
          end
        end
        SEQ_COMBINE_WAIT: begin
          if (comb_done) begin
            res_req   <= 1'b1;
            comb_take <= 1'b1;
            state_q   <= SEQ_RESULT_HOLD;
          end
        end
        // Next row stalls here until the sink completes
        SEQ_RESULT_HOLD: begin
          if (res_ack) begin
            res_req <= 1'b0;
            state_q <= SEQ_RESULT_RELEASE;
          end
        end
        SEQ_RESULT_RELEASE: begin
          if (!res_ack) begin
            if (job_end) begin
              done    <= 1'b1;
              state_q <= SEQ_IDLE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              state_q <= SEQ_ROW_START;
            end
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      elem.a    <= elem_a;
      elem.b    <= elem_b;
      elem.last <= row_end;
    end
    // Copied as the combiner is released
    if (take_result) begin
      res_value <= comb_result;
      res_zero  <= comb_zero;
    end
  end

  // Ack only answers a request sampled high
  a_ack_follows_req : assert property (
    @(posedge CLK) disable iff (RST) $rose(elem_ack) |-> $past(elem_req)
  ) else $error("elem_ack rose without elem_req");

  // Result offered until the sink answers
  a_res_req_held : assert property (
    @(posedge CLK) disable iff (RST) (res_req && !res_ack) |=> res_req
  ) else $error("res_req dropped before res_ack");

endmodule

// File: hw/cosine_similarity_top.sv
// Cosine similarity engine top level, wires the sequencer, both accumulators and the combiner
`timescale 1ns/100ps

module cosine_similarity_top #(
  parameter int DATA_W    = cosine_fmt_pkg::DATA_W_DEF,
  parameter int LEN_W     = cosine_fmt_pkg::LEN_W_DEF,
  parameter int FRAC_BITS = cosine_fmt_pkg::FRAC_BITS_DEF
) (
  input  logic CLK,
  input  logic RST,

  // Job control
  input  logic start,
  input  logic [LEN_W-1:0] rows,
  input  logic [LEN_W-1:0] length,
  output logic done,

  // Element handshake
  input  logic elem_req,
  input  logic signed [DATA_W-1:0] elem_a,
  input  logic signed [DATA_W-1:0] elem_b,
  output logic elem_ack,

  // Result handshake
  output logic res_req,
  output logic signed [cosine_fmt_pkg::res_width(FRAC_BITS)-1:0] res_value,
  output logic res_zero,
  input  logic res_ack
);

  import cosine_fmt_pkg::*;

  localparam int ACC_W = acc_width(DATA_W, LEN_W);
  localparam int RES_W = res_width(FRAC_BITS);

  // Row sums
  logic signed [ACC_W-1:0] dot_sum;
  logic [ACC_W-1:0] norm_a;
  logic [ACC_W-1:0] norm_b;
  logic dot_valid;
  logic norm_valid;

  // Combiner handshake
  logic comb_done;
  logic comb_take;
  logic comb_zero;
  logic signed [RES_W-1:0] comb_result;

  element_if #(.DATA_W(DATA_W)) elem_bus ();

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  cosine_row_sequencer #(
    .DATA_W(DATA_W), .LEN_W(LEN_W), .FRAC_BITS(FRAC_BITS)
  ) u_seq (
    .CLK(CLK), .RST(RST),
    .start(start), .rows(rows), .length(length), .done(done),
    .elem_req(elem_req), .elem_a(elem_a), .elem_b(elem_b), .elem_ack(elem_ack),
    .comb_done(comb_done), .comb_result(comb_result), .comb_zero(comb_zero),
    .comb_take(comb_take),
    .res_req(res_req), .res_value(res_value), .res_zero(res_zero), .res_ack(res_ack),
    .elem(elem_bus.src)
  );

  dot_accumulator #(
    .DATA_W(DATA_W), .LEN_W(LEN_W)
  ) u_dot (
    .CLK(CLK), .RST(RST),
    .elem(elem_bus.acc),
    .dot_sum(dot_sum), .sum_valid(dot_valid)
  );

  norm_accumulator #(
    .DATA_W(DATA_W), .LEN_W(LEN_W)
  ) u_norm (
    .CLK(CLK), .RST(RST),
    .elem(elem_bus.acc),
    .norm_a(norm_a), .norm_b(norm_b), .sum_valid(norm_valid)
  );

  // Starts once both row sums are complete
  cosine_combiner #(
    .DATA_W(DATA_W), .LEN_W(LEN_W), .FRAC_BITS(FRAC_BITS)
  ) u_comb (
    .CLK(CLK), .RST(RST),
    .start_dot(dot_valid), .start_norm(norm_valid),
    .dot_sum(dot_sum), .norm_a(norm_a), .norm_b(norm_b),
    .comb_take(comb_take), .comb_done(comb_done),
    .comb_result(comb_result), .comb_zero(comb_zero)
  );

endmodule
